// ==== cart_loader.f ====
design/cart_pkg.sv
design/dl_if.sv
design/cart_ctrl.sv
design/header_detect.sv
design/cheat_assembler.sv
design/ram_fill.sv
design/backup_sequencer.sv
design/cart_loader_top.sv
tb/cart_loader_tb.sv

// ==== design/backup_sequencer.sv ====
`timescale 1ns/1ps

module backup_sequencer (
	input  logic                        clk_sys,
	input  logic                        RESET,
	input  logic                        bk_ena,
	input  logic                        auto_load,
	input  logic                        bk_load_req,
	input  logic                        bk_save_req,
	input  logic [cart_pkg::mask_w-1:0] ram_mask,
	output logic [cart_pkg::lba_w-1:0]  sd_lba,
	output logic                        sd_rd,
	output logic                        sd_wr,
	input  logic                        sd_ack,
	output logic                        bk_loading,
	output logic                        bk_busy
);
	import cart_pkg::*;

	logic             load_q;
	logic             save_q;
	logic             ack_q;
	logic             load_rise;
	logic             save_rise;
	logic             ack_rise;
	logic             ack_fall;
	logic             start_load;
	logic [lba_w-1:0] last_lba;

	// ====================
	// Edge detect
	// ====================
	assign load_rise  = bk_load_req && !load_q && bk_ena;
	assign save_rise  = bk_save_req && !save_q && bk_ena;
	assign ack_rise   = sd_ack && !ack_q;
	assign ack_fall   = !sd_ack && ack_q;
	assign start_load = auto_load || load_rise;

	// 512-byte blocks covering the backup RAM
	assign last_lba = lba_w'(ram_mask[23:9]);

	// ====================
	// Block sequencer
	// ====================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			load_q     <= 1'b0;
			save_q     <= 1'b0;
			ack_q      <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
		end else begin
			load_q <= bk_load_req;
			save_q <= bk_save_req;
			ack_q  <= sd_ack;

			// Storage side has taken the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (!bk_busy) begin
				// Load wins when both requests rise together
				if (start_load || save_rise) begin
					bk_busy    <= 1'b1;
					bk_loading <= start_load;
					sd_lba     <= '0;
					sd_rd      <= start_load;
					sd_wr      <= !start_load;
				end
			end else if (ack_fall) begin
				if (sd_lba >= last_lba) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd  <= bk_loading;
					sd_wr  <= !bk_loading;
				end
			end
		end
	end

	// Requests only inside a transfer
	a_req_busy: assert property (
		@(posedge clk_sys) disable iff (RESET)
		(sd_rd || sd_wr) |-> bk_busy
	) else $error("storage request raised while idle");

endmodule

// ==== design/cart_ctrl.sv ====
`timescale 1ns/1ps

module cart_ctrl (
	input  logic                        clk_sys,
	input  logic                        RESET,
	input  logic                        dl_download,
	input  logic [7:0]                  dl_index,
	dl_if.ctrl                          dl,
	input  logic                        img_mounted,
	input  logic                        img_readonly,
	input  logic [63:0]                 img_size,
	input  logic [cart_pkg::mask_w-1:0] ram_mask,
	input  logic                        clearing,
	input  logic                        bk_loading,
	output logic                        fill_start,
	output logic                        bk_ena,
	output logic                        auto_load,
	output logic                        core_reset
);
	import cart_pkg::*;

	logic cart_dl;
	logic cart_dl_q;
	logic cart_rise;
	logic cart_fall;

	// ====================
	// Index decode
	// ====================
	assign cart_dl     = dl_download && (dl_index == idx_cart);
	assign dl.cart_sel = cart_dl;
	assign dl.code_sel = dl_download && (dl_index == idx_code);

	assign cart_rise = cart_dl && !cart_dl_q;
	assign cart_fall = !cart_dl && cart_dl_q;

	// ====================
	// Download edges
	// ====================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q  <= 1'b0;
			fill_start <= 1'b0;
			auto_load  <= 1'b0;
			bk_ena     <= 1'b0;
		end else begin
			cart_dl_q  <= cart_dl;
			fill_start <= cart_rise;
			// Pull the save file in once the image is complete
			auto_load  <= cart_fall && (|img_size) && bk_ena;

			if (cart_rise) begin
				bk_ena <= 1'b0;
			end else if (cart_dl && img_mounted && !img_readonly) begin
				// Save file is mounted by the end of the download
				bk_ena <= |ram_mask;
			end
		end
	end

	// Hold the console while anything rewrites its memories
	assign core_reset = RESET || cart_dl || clearing || bk_loading;

	// Clear follows its start pulse by one cycle
	a_fill_follows: assert property (
		@(posedge clk_sys) disable iff (RESET)
		fill_start |=> clearing
	) else $error("clearing did not follow fill_start");

endmodule

// ==== design/cart_loader_top.sv ====
`timescale 1ns/1ps

module cart_loader_top (
	input  logic                             clk_sys,
	input  logic                             RESET,
	// Download stream
	input  logic                             dl_download,
	input  logic [7:0]                       dl_index,
	input  logic [cart_pkg::dl_addr_w-1:0]   dl_addr,
	input  logic [cart_pkg::dl_data_w-1:0]   dl_data,
	input  logic                             dl_wr,
	// Menu settings
	input  cart_pkg::hdr_mode_t              hdr_mode,
	input  cart_pkg::fill_mode_t             fill_mode,
	// Save image
	input  logic                             img_mounted,
	input  logic                             img_readonly,
	input  logic [63:0]                      img_size,
	input  logic                             bk_load_req,
	input  logic                             bk_save_req,
	// Block storage
	output logic [cart_pkg::lba_w-1:0]       sd_lba,
	output logic                             sd_rd,
	output logic                             sd_wr,
	input  logic                             sd_ack,
	// Cartridge info
	output logic [7:0]                       rom_type,
	output logic                             rom_region,
	output logic [cart_pkg::mask_w-1:0]      rom_mask,
	output logic [cart_pkg::mask_w-1:0]      ram_mask,
	output logic [127:0]                     gg_code,
	output logic                             gg_valid,
	// Work RAM clear port
	output logic [cart_pkg::wram_addr_w-1:0] fill_addr,
	output logic [7:0]                       fill_data,
	output logic                             fill_we,
	output logic                             core_reset,
	output logic                             bk_busy
);

	logic fill_start;
	logic clearing;
	logic bk_ena;
	logic auto_load;
	logic bk_loading;

	dl_if dl_if ();

	assign dl_if.addr = dl_addr;
	assign dl_if.data = dl_data;
	assign dl_if.wr   = dl_wr;

	// ====================
	// Control
	// ====================
	cart_ctrl cart_ctrl (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.dl_download  (dl_download),
		.dl_index     (dl_index),
		.dl           (dl_if.ctrl),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.ram_mask     (ram_mask),
		.clearing     (clearing),
		.bk_loading   (bk_loading),
		.fill_start   (fill_start),
		.bk_ena       (bk_ena),
		.auto_load    (auto_load),
		.core_reset   (core_reset)
	);

	// ====================
	// Datapath
	// ====================
	header_detect header_detect (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.dl         (dl_if.sink),
		.hdr_mode   (hdr_mode),
		.rom_type   (rom_type),
		.rom_region (rom_region),
		.rom_mask   (rom_mask),
		.ram_mask   (ram_mask)
	);

	cheat_assembler cheat_assembler (
		.clk_sys  (clk_sys),
		.RESET    (RESET),
		.dl       (dl_if.sink),
		.gg_code  (gg_code),
		.gg_valid (gg_valid)
	);

	ram_fill ram_fill (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.fill_start (fill_start),
		.fill_mode  (fill_mode),
		.clearing   (clearing),
		.fill_addr  (fill_addr),
		.fill_data  (fill_data),
		.fill_we    (fill_we)
	);

	backup_sequencer backup_sequencer (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.bk_ena      (bk_ena),
		.auto_load   (auto_load),
		.bk_load_req (bk_load_req),
		.bk_save_req (bk_save_req),
		.ram_mask    (ram_mask),
		.sd_lba      (sd_lba),
		.sd_rd       (sd_rd),
		.sd_wr       (sd_wr),
		.sd_ack      (sd_ack),
		.bk_loading  (bk_loading),
		.bk_busy     (bk_busy)
	);

endmodule

// ==== design/cart_pkg.sv ====
package cart_pkg;

	// ====================
	// Widths
	// ====================
	localparam int dl_addr_w   = 25;
	localparam int dl_data_w   = 16;
	localparam int mask_w      = 24;
	localparam int wram_addr_w = 12;
	localparam int lba_w       = 32;

	// Download index codes
	localparam logic [7:0] idx_cart = 8'd0;
	localparam logic [7:0] idx_code = 8'd255;

	// ====================
	// Cartridge header
	// ====================
	// Copier header that precedes the image
	localparam int hdr_bias = 512;

	// ROM size word per mapping; the RAM size word is two bytes above
	localparam logic [dl_addr_w-1:0] lorom_size_addr   = dl_addr_w'('h7FD6 + hdr_bias);
	localparam logic [dl_addr_w-1:0] hirom_size_addr   = dl_addr_w'('hFFD6 + hdr_bias);
	localparam logic [dl_addr_w-1:0] exhirom_size_addr = dl_addr_w'('h40FFD6 + hdr_bias);

	localparam logic [3:0] default_rom_size = 4'd12;

	// Header mode select
	typedef logic [2:0] hdr_mode_t;
	localparam hdr_mode_t hdr_auto    = 3'd0;
	localparam hdr_mode_t hdr_none    = 3'd1;
	localparam hdr_mode_t hdr_lorom   = 3'd2;
	localparam hdr_mode_t hdr_hirom   = 3'd3;
	localparam hdr_mode_t hdr_exhirom = 3'd4;

	// Work RAM power-on pattern select
	typedef logic [1:0] fill_mode_t;

	// Cheat code, 128 bits, flags on top
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

// ==== design/cheat_assembler.sv ====
`timescale 1ns/1ps

module cheat_assembler (
	input  logic                  clk_sys,
	input  logic                  RESET,
	dl_if.sink                    dl,
	output cart_pkg::cheat_code_t gg_code,
	output logic                  gg_valid
);

	logic code_wr;

	assign code_wr = dl.code_sel && dl.wr;

	// Each 32-bit field arrives low half first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl.addr[3:0])
				4'd0:    gg_code.flags[15:0]    <= dl.data;
				4'd2:    gg_code.flags[31:16]   <= dl.data;
				4'd4:    gg_code.addr[15:0]     <= dl.data;
				4'd6:    gg_code.addr[31:16]    <= dl.data;
				4'd8:    gg_code.compare[15:0]  <= dl.data;
				4'd10:   gg_code.compare[31:16] <= dl.data;
				4'd12:   gg_code.replace[15:0]  <= dl.data;
				4'd14:   gg_code.replace[31:16] <= dl.data;
				default: ;
			endcase
		end
	end

	// Last word completes the code
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			gg_valid <= 1'b0;
		end else begin
			gg_valid <= code_wr && (dl.addr[3:0] == 4'd14);
		end
	end

endmodule

// ==== design/dl_if.sv ====
`timescale 1ns/1ps

interface dl_if;
	import cart_pkg::*;

	// Raw stream from the host side
	logic [dl_addr_w-1:0] addr;
	logic [dl_data_w-1:0] data;
	logic                 wr;

	// Index decode, high while the matching download runs
	logic                 cart_sel;
	logic                 code_sel;

	modport host (output addr, output data, output wr);

	modport ctrl (output cart_sel, output code_sel);

	modport sink (
		input addr,
		input data,
		input wr,
		input cart_sel,
		input code_sel
	);

endinterface

// ==== design/header_detect.sv ====
`timescale 1ns/1ps

module header_detect (
	input  logic                        clk_sys,
	input  logic                        RESET,
	dl_if.sink                          dl,
	input  cart_pkg::hdr_mode_t         hdr_mode,
	output logic [7:0]                  rom_type,
	output logic                        rom_region,
	output logic [cart_pkg::mask_w-1:0] rom_mask,
	output logic [cart_pkg::mask_w-1:0] ram_mask
);
	import cart_pkg::*;

	logic [3:0]           rom_size;
	logic [3:0]           ram_size;
	logic [3:0]           rom_size_nxt;
	logic [3:0]           ram_size_nxt;
	logic [dl_addr_w-1:0] size_addr;
	logic [dl_addr_w-1:0] ram_addr;
	logic                 mapped;
	logic                 hdr_wr;

	function automatic logic [mask_w-1:0] size_mask(input logic [3:0] size);
		size_mask = (mask_w'(1024) << size) - 1'b1;
	endfunction

	assign hdr_wr = dl.cart_sel && dl.wr;

	// Size word location for the forced mappings
	always_comb begin
		mapped    = 1'b1;
		size_addr = lorom_size_addr;
		case (hdr_mode)
			hdr_lorom:   size_addr = lorom_size_addr;
			hdr_hirom:   size_addr = hirom_size_addr;
			hdr_exhirom: size_addr = exhirom_size_addr;
			default:     mapped = 1'b0;
		endcase
	end

	assign ram_addr = size_addr + dl_addr_w'(2);

	// Size codes after this write, so masks follow in one cycle
	always_comb begin
		rom_size_nxt = rom_size;
		ram_size_nxt = ram_size;
		if (dl.addr == '0) begin
			rom_size_nxt = default_rom_size;
			ram_size_nxt = 4'd0;
			// Auto mode takes sizes from the first byte when present
			if (hdr_mode == hdr_auto && dl.data[7:0] != 8'd0) begin
				{ram_size_nxt, rom_size_nxt} = dl.data[7:0];
			end
		end
		if (mapped && dl.addr == size_addr) begin
			rom_size_nxt = dl.data[11:8];
		end
		if (mapped && dl.addr == ram_addr) begin
			ram_size_nxt = dl.data[3:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= '0;
			ram_size   <= '0;
			rom_type   <= '0;
			rom_region <= 1'b0;
			rom_mask   <= '0;
			ram_mask   <= '0;
		end else if (hdr_wr) begin
			rom_size <= rom_size_nxt;
			ram_size <= ram_size_nxt;
			rom_mask <= size_mask(rom_size_nxt);
			ram_mask <= (ram_size_nxt != 4'd0) ? size_mask(ram_size_nxt) : '0;

			if (dl.addr == '0) begin
				case (hdr_mode)
					hdr_none:    rom_type <= 8'd0;
					hdr_lorom:   rom_type <= 8'd0;
					hdr_hirom:   rom_type <= 8'd1;
					hdr_exhirom: rom_type <= 8'd2;
					default:     rom_type <= dl.data[15:8];
				endcase
			end

			if (dl.addr == dl_addr_w'(2)) begin
				rom_region <= dl.data[8];
			end
		end
	end

endmodule

// ==== design/ram_fill.sv ====
`timescale 1ns/1ps

module ram_fill (
	input  logic                             clk_sys,
	input  logic                             RESET,
	input  logic                             fill_start,
	input  cart_pkg::fill_mode_t             fill_mode,
	output logic                             clearing,
	output logic [cart_pkg::wram_addr_w-1:0] fill_addr,
	output logic [7:0]                       fill_data,
	output logic                             fill_we
);

	// One write per cycle over the whole work RAM
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clearing  <= 1'b0;
			fill_addr <= '0;
		end else begin
			if (clearing) begin
				if (&fill_addr) begin
					clearing <= 1'b0;
				end
			end else if (fill_start) begin
				clearing <= 1'b1;
			end
			fill_addr <= clearing ? fill_addr + 1'b1 : '0;
		end
	end

	assign fill_we = clearing;

	// Power-on patterns of the different console revisions
	always_comb begin
		case (fill_mode)
			2'd0:    fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			2'd1:    fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			2'd2:    fill_data = 8'h55;
			default: fill_data = 8'hFF;
		endcase
	end

	// Counter parks at zero between clears
	a_addr_idle: assert property (
		@(posedge clk_sys) disable iff (RESET)
		!clearing |-> (fill_addr == '0)
	) else $error("fill_addr nonzero while idle");

endmodule

// ==== tb/cart_loader_tb.sv ====
`timescale 1ns/1ps

module cart_loader_tb;
	import cart_pkg::*;

	// Seven cartridge downloads, each followed by a full clear; the rest is
	// downloads, cheat words and up to three 16-block backup transfers
	localparam int num_clears   = 7;
	localparam int clear_cycles = (1 << wram_addr_w) + 200;
	localparam int max_blocks   = 48;
	localparam int block_cycles = 12;
	localparam int max_cycles   = num_clears * clear_cycles + max_blocks * block_cycles + 10000;

	logic                   clk_sys = 1'b0;
	logic                   RESET;
	logic                   dl_download;
	logic [7:0]             dl_index;
	logic [dl_addr_w-1:0]   dl_addr;
	logic [dl_data_w-1:0]   dl_data;
	logic                   dl_wr;
	hdr_mode_t              hdr_mode;
	fill_mode_t             fill_mode;
	logic                   img_mounted;
	logic                   img_readonly;
	logic [63:0]            img_size;
	logic                   bk_load_req;
	logic                   bk_save_req;
	logic [lba_w-1:0]       sd_lba;
	logic                   sd_rd;
	logic                   sd_wr;
	logic                   sd_ack;
	logic [7:0]             rom_type;
	logic                   rom_region;
	logic [mask_w-1:0]      rom_mask;
	logic [mask_w-1:0]      ram_mask;
	logic [127:0]           gg_code;
	logic                   gg_valid;
	logic [wram_addr_w-1:0] fill_addr;
	logic [7:0]             fill_data;
	logic                   fill_we;
	logic                   core_reset;
	logic                   bk_busy;

	// Bookkeeping shared by the checkers and the main flow
	int          errors;
	int          fill_errors;
	int          tests_run;
	int          tests_failed;
	int          cycles;
	int          dl_num;
	int          clears_done;
	int          clear_target;
	int          fill_count;
	logic        fill_we_q;
	int          gg_pulses;
	logic        gg_valid_q;
	cheat_code_t exp_codes[$];
	int          blocks_seen;
	int          rd_blocks;
	int          wr_blocks;
	logic [7:0]        exp_type;
	logic              exp_region;
	logic [mask_w-1:0] exp_rom_mask;
	logic [mask_w-1:0] exp_ram_mask;

	cart_loader_top cart_loader_top_i (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.dl_download  (dl_download),
		.dl_index     (dl_index),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.dl_wr        (dl_wr),
		.hdr_mode     (hdr_mode),
		.fill_mode    (fill_mode),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.bk_load_req  (bk_load_req),
		.bk_save_req  (bk_save_req),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_ack       (sd_ack),
		.rom_type     (rom_type),
		.rom_region   (rom_region),
		.rom_mask     (rom_mask),
		.ram_mask     (ram_mask),
		.gg_code      (gg_code),
		.gg_valid     (gg_valid),
		.fill_addr    (fill_addr),
		.fill_data    (fill_data),
		.fill_we      (fill_we),
		.core_reset   (core_reset),
		.bk_busy      (bk_busy)
	);

	always #5 clk_sys = ~clk_sys;

	// ====================
	// Reference model
	// ====================
	function automatic logic [mask_w-1:0] ref_mask(input logic [3:0] size);
		logic [31:0] full;
		full = (32'd1024 << size) - 32'd1;
		return full[mask_w-1:0];
	endfunction

	// RAM size code in the high nibble, ROM size code in the low one
	function automatic logic [7:0] ref_sizes(input hdr_mode_t mode, input logic [15:0] w0,
			input logic [15:0] wrom, input logic [15:0] wram);
		logic [3:0] rom_sz;
		logic [3:0] ram_sz;
		rom_sz = default_rom_size;
		ram_sz = 4'd0;
		if (mode == hdr_auto && w0[7:0] != 8'd0) begin
			rom_sz = w0[3:0];
			ram_sz = w0[7:4];
		end
		if (mode >= hdr_lorom && mode <= hdr_exhirom) begin
			rom_sz = wrom[11:8];
			ram_sz = wram[3:0];
		end
		return {ram_sz, rom_sz};
	endfunction

	function automatic logic [7:0] ref_type(input hdr_mode_t mode, input logic [15:0] w0);
		case (mode)
			hdr_auto:    return w0[15:8];
			hdr_hirom:   return 8'd1;
			hdr_exhirom: return 8'd2;
			default:     return 8'd0;
		endcase
	endfunction

	function automatic logic [7:0] fill_pattern(input fill_mode_t mode,
			input logic [wram_addr_w-1:0] a);
		case (mode)
			2'd0:    return (a[8] != a[2]) ? 8'h66 : 8'h99;
			2'd1:    return (a[9] != a[0]) ? 8'hFF : 8'h00;
			2'd2:    return 8'h55;
			default: return 8'hFF;
		endcase
	endfunction

	// ====================
	// Checkers
	// ====================
	// Clear length and pattern, one write per cycle
	always @(negedge clk_sys) begin
		if (RESET) begin
			fill_count = 0;
			fill_we_q  = 1'b0;
		end else begin
			if (fill_we) begin
				assert (fill_addr == wram_addr_w'(fill_count)) else begin
					$display("MISMATCH fill_addr: got %h expected %h", fill_addr,
						wram_addr_w'(fill_count));
					fill_errors++;
				end
				assert (fill_data == fill_pattern(fill_mode, fill_addr)) else begin
					$display("MISMATCH fill_data: got %h expected %h at addr %h mode %h",
						fill_data, fill_pattern(fill_mode, fill_addr), fill_addr, fill_mode);
					fill_errors++;
				end
				fill_count++;
			end else if (fill_we_q) begin
				assert (fill_count == (1 << wram_addr_w)) else begin
					$display("Clear wrote %0d words instead of %0d", fill_count,
						1 << wram_addr_w);
					fill_errors++;
				end
				clears_done++;
				fill_count = 0;
			end
			fill_we_q = fill_we;
		end
	end

	// Cheat codes against the queue of sent codes
	always @(negedge clk_sys) begin
		if (RESET) begin
			gg_valid_q = 1'b0;
		end else begin
			if (gg_valid) begin
				gg_pulses++;
				assert (!gg_valid_q) else begin
					$display("gg_valid stayed high for more than one cycle");
					errors++;
				end
				if (exp_codes.size() == 0) begin
					$display("gg_valid pulsed with no cheat code pending");
					errors++;
				end else begin
					assert (gg_code == exp_codes[0]) else begin
						$display("MISMATCH gg_code: got %h expected %h", gg_code, exp_codes[0]);
						errors++;
					end
					void'(exp_codes.pop_front());
				end
			end
			gg_valid_q = gg_valid;
		end
	end

	always @(negedge clk_sys) begin
		if (!RESET) begin
			assert (!(sd_rd && sd_wr)) else begin
				$display("sd_rd and sd_wr both high at lba %h", sd_lba);
				errors++;
			end
		end
	end

	// Storage side: ack after 1 to 4 cycles, held for two
	initial begin : storage_responder
		int delay;
		sd_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (!RESET && (sd_rd || sd_wr)) begin
				assert (sd_lba == lba_w'(blocks_seen)) else begin
					$display("MISMATCH sd_lba: got %h expected %h", sd_lba, lba_w'(blocks_seen));
					errors++;
				end
				blocks_seen++;
				if (sd_rd) begin
					rd_blocks++;
				end else begin
					wr_blocks++;
				end
				delay = 1 + ($urandom % 4);
				repeat (delay) @(posedge clk_sys);
				sd_ack <= 1'b1;
				repeat (2) @(posedge clk_sys);
				sd_ack <= 1'b0;
			end
		end
	end

	initial begin : watchdog
		cycles = 0;
		while (cycles < max_cycles) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Run stopped by timeout after %0d cycles", cycles);
		$display("TB FAILED");
		$finish;
	end

	// ====================
	// Stimulus tasks
	// ====================
	task automatic send_word(input logic [dl_addr_w-1:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		dl_addr <= addr;
		dl_data <= data;
		dl_wr   <= 1'b1;
		@(posedge clk_sys);
		dl_wr   <= 1'b0;
	endtask

	task automatic begin_download(input logic [7:0] index);
		@(posedge clk_sys);
		dl_index    <= index;
		dl_download <= 1'b1;
	endtask

	task automatic end_download;
		@(posedge clk_sys);
		dl_download <= 1'b0;
	endtask

	// Sparse image with just the header words; ram_fixed 0 keeps the RAM size random
	task automatic load_cart(input hdr_mode_t mode, input logic [3:0] ram_fixed);
		logic [15:0]          w0;
		logic [15:0]          w2;
		logic [15:0]          wrom;
		logic [15:0]          wram;
		logic [dl_addr_w-1:0] sz_addr;
		logic [7:0]           sizes;
		w0   = 16'($urandom);
		w2   = 16'($urandom);
		wrom = 16'($urandom);
		wram = 16'($urandom);
		if (ram_fixed != 4'd0) begin
			wram[3:0] = ram_fixed;
		end
		case (mode)
			hdr_hirom:   sz_addr = hirom_size_addr;
			hdr_exhirom: sz_addr = exhirom_size_addr;
			default:     sz_addr = lorom_size_addr;
		endcase
		sizes        = ref_sizes(mode, w0, wrom, wram);
		exp_type     = ref_type(mode, w0);
		exp_region   = w2[8];
		exp_rom_mask = ref_mask(sizes[3:0]);
		exp_ram_mask = (sizes[7:4] == 4'd0) ? '0 : ref_mask(sizes[7:4]);
		clear_target = clears_done + 1;
		@(posedge clk_sys);
		hdr_mode  <= mode;
		fill_mode <= fill_mode_t'(dl_num % 4);
		dl_num++;
		begin_download(idx_cart);
		send_word('0, w0);
		send_word(dl_addr_w'(2), w2);
		send_word(sz_addr, wrom);
		send_word(sz_addr + dl_addr_w'(2), wram);
		end_download();
	endtask

	task automatic send_cheat(input int slot);
		logic [15:0] words [0:7];
		cheat_code_t expected;
		for (int k = 0; k < 8; k++) begin
			words[k] = 16'($urandom);
		end
		expected.flags   = {words[1], words[0]};
		expected.addr    = {words[3], words[2]};
		expected.compare = {words[5], words[4]};
		expected.replace = {words[7], words[6]};
		exp_codes.push_back(expected);
		begin_download(idx_code);
		for (int k = 0; k < 8; k++) begin
			send_word(dl_addr_w'(slot * 16 + 2 * k), words[k]);
		end
		end_download();
	endtask

	task automatic pulse_save;
		@(posedge clk_sys);
		bk_save_req <= 1'b1;
		@(posedge clk_sys);
		bk_save_req <= 1'b0;
	endtask

	task automatic pulse_load;
		@(posedge clk_sys);
		bk_load_req <= 1'b1;
		@(posedge clk_sys);
		bk_load_req <= 1'b0;
	endtask

	task automatic wait_clear;
		wait (clears_done >= clear_target);
		@(negedge clk_sys);
	endtask

	task automatic check_header;
		assert (rom_type == exp_type) else begin
			$display("MISMATCH rom_type: got %h expected %h", rom_type, exp_type);
			errors++;
		end
		assert (rom_region == exp_region) else begin
			$display("MISMATCH rom_region: got %h expected %h", rom_region, exp_region);
			errors++;
		end
		assert (rom_mask == exp_rom_mask) else begin
			$display("MISMATCH rom_mask: got %h expected %h", rom_mask, exp_rom_mask);
			errors++;
		end
		assert (ram_mask == exp_ram_mask) else begin
			$display("MISMATCH ram_mask: got %h expected %h", ram_mask, exp_ram_mask);
			errors++;
		end
	endtask

	task automatic clear_block_counts;
		blocks_seen = 0;
		rd_blocks   = 0;
		wr_blocks   = 0;
	endtask

	task automatic finish_test(input string name, input int n_err);
		tests_run++;
		if (n_err == 0) begin
			$display("Test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: %0d errors", tests_run, name, n_err);
		end
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin : main_flow
		int start_err;
		int blocks;
		logic busy_seen;
		RESET        = 1'b1;
		dl_download  = 1'b0;
		dl_index     = 8'd0;
		dl_addr      = '0;
		dl_data      = '0;
		dl_wr        = 1'b0;
		hdr_mode     = hdr_auto;
		fill_mode    = 2'd0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size     = '0;
		bk_load_req  = 1'b0;
		bk_save_req  = 1'b0;
		errors       = 0;
		fill_errors  = 0;
		tests_run    = 0;
		tests_failed = 0;
		dl_num       = 0;
		clears_done  = 0;
		gg_pulses    = 0;
		clear_block_counts();
		void'($urandom(32'hdd33_df8a));

		repeat (9) @(posedge clk_sys);
		@(negedge clk_sys);
		start_err = errors;
		assert (!sd_rd && !sd_wr && !gg_valid && !fill_we && !bk_busy && core_reset) else begin
			$display("Outputs not in their reset state while RESET is high");
			errors++;
		end
		@(posedge clk_sys);
		RESET <= 1'b0;
		finish_test("reset state", errors - start_err);

		// Header in every mode, clear patterns cycle along
		start_err = errors;
		for (int m = 0; m < 5; m++) begin
			load_cart(hdr_mode_t'(m), 4'd0);
			wait_clear();
			check_header();
		end
		finish_test("header detect", errors - start_err);

		start_err = errors;
		for (int s = 0; s < 3; s++) begin
			send_cheat(s);
		end
		repeat (3) @(negedge clk_sys);
		assert (gg_pulses == 3 && exp_codes.size() == 0) else begin
			$display("gg_valid pulsed %0d times for 3 cheat codes", gg_pulses);
			errors++;
		end
		finish_test("cheat codes", errors - start_err);

		// Writable save image, load runs behind the download
		start_err = errors;
		clear_block_counts();
		@(posedge clk_sys);
		img_mounted  <= 1'b1;
		img_readonly <= 1'b0;
		img_size     <= 64'h8000;
		load_cart(hdr_lorom, 4'd1 + 4'($urandom % 3));
		blocks = int'(exp_ram_mask[23:9]) + 1;
		while (!bk_busy) begin
			@(negedge clk_sys);
			assert (core_reset) else begin
				$display("core_reset low before the backup load started");
				errors++;
			end
		end
		while (bk_busy) begin
			@(negedge clk_sys);
			assert (core_reset) else begin
				$display("core_reset low during the backup load at lba %h", sd_lba);
				errors++;
			end
		end
		assert (rd_blocks == blocks && wr_blocks == 0) else begin
			$display("Auto load moved %0d read and %0d write blocks, expected %0d reads",
				rd_blocks, wr_blocks, blocks);
			errors++;
		end
		wait_clear();
		check_header();

		// Requested load after the clear, so only the load holds the core
		clear_block_counts();
		pulse_load();
		while (!bk_busy) @(negedge clk_sys);
		while (bk_busy) begin
			assert (core_reset) else begin
				$display("core_reset low during a requested load at lba %h", sd_lba);
				errors++;
			end
			@(negedge clk_sys);
		end
		assert (!core_reset && rd_blocks == blocks && wr_blocks == 0) else begin
			$display("Requested load moved %0d read blocks for %0d, core_reset %h after it",
				rd_blocks, blocks, core_reset);
			errors++;
		end
		finish_test("automatic backup load", errors - start_err);

		start_err = errors;
		clear_block_counts();
		pulse_save();
		while (!bk_busy) @(negedge clk_sys);
		while (bk_busy) @(negedge clk_sys);
		assert (wr_blocks == blocks && rd_blocks == 0) else begin
			$display("Save moved %0d write and %0d read blocks, expected %0d writes",
				wr_blocks, rd_blocks, blocks);
			errors++;
		end
		// Read-only image leaves saving disabled
		@(posedge clk_sys);
		img_readonly <= 1'b1;
		clear_block_counts();
		load_cart(hdr_lorom, 4'd2);
		wait_clear();
		pulse_save();
		busy_seen = 1'b0;
		repeat (50) begin
			@(negedge clk_sys);
			busy_seen = busy_seen | bk_busy;
		end
		assert (blocks_seen == 0 && !busy_seen) else begin
			$display("Storage request issued with a read-only save image");
			errors++;
		end
		finish_test("backup save", errors - start_err);

		assert (clears_done == dl_num) else begin
			$display("Saw %0d clears for %0d cartridge downloads", clears_done, dl_num);
			fill_errors++;
		end
		finish_test("work RAM clear", fill_errors);

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
			errors + fill_errors);
		if (tests_failed == 0 && errors + fill_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule
